//--- filelist.f
logic/mig_app_pkg.sv
logic/memtest_pkg.sv
logic/pattern_lfsr.sv
logic/size_probe.sv
logic/burst_sweeper.sv
logic/memtest_top.sv
sim/dram_model.sv
sim/memtest_properties.sv
sim/memtest_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, then run it and look for the pass line
verilator --binary --assert -Wno-fatal --top-module memtest_tb -f filelist.f -Mdir obj_dir \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vmemtest_tb)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1

//--- sim/memtest_tb.sv
`timescale 1ns/100ps

module memtest_tb;

  localparam int ADDR_W      = 12;
  localparam int WORDS       = 2 ** (ADDR_W - 3);
  localparam int HALF        = 2 ** (ADDR_W - 1);
  localparam int BURSTS      = (2 ** ADDR_W) / 64;
  // worst burst under heavy stalls in cycles
  localparam int WORST_BURST = 600;
  localparam int RUN_CYCLES  = 4 * BURSTS * WORST_BURST + 2000;
  localparam int NUM_RUNS    = 6;
  localparam int FAULT_WORD  = 300;

  logic                  clk;
  logic                  rstn;
  logic                  calib;
  logic                  alias_on;
  int                    stall_pct;
  logic                  corrupt_first;
  logic                  fault_arm;
  int                    fault_word;
  mig_app_pkg::app_req_t req;
  mig_app_pkg::app_rsp_t rsp;
  memtest_pkg::phase_e   phase;
  memtest_pkg::status_t  status;

  int          errors;
  int          wr_cmds;
  int          rd_cmds;
  int          wr_bursts;
  int          rd_bursts;
  int          wr_beats;
  int          open_beats;
  int          high_writes;
  int          inv_reads;
  logic [26:0] last_rd;
  logic [26:0] acc_lin;
  bit          saw_fail;

  memtest_top #(
    .ADDR_W (ADDR_W)
  ) UUT (
    .clk                   (clk),
    .rstn                  (rstn),
    .init_calib_complete_i (calib),
    .app_rsp_i             (rsp),
    .app_req_o             (req),
    .phase_o               (phase),
    .status_o              (status)
  );

  dram_model #(
    .ADDR_W (ADDR_W)
  ) u_dram (
    .clk             (clk),
    .rstn            (rstn),
    .alias_i         (alias_on),
    .stall_pct_i     (stall_pct),
    .corrupt_first_i (corrupt_first),
    .fault_arm_i     (fault_arm),
    .fault_word_i    (fault_word),
    .req_i           (req),
    .rsp_o           (rsp)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // flat count is row, bank, col from the top down
  function automatic logic [26:0] linear_of(logic [26:0] port);
    return {port[23:10], port[26:24], port[9:0]};
  endfunction

  // reference pattern with taps 68 67 66 63 into bit 0
  function automatic logic [127:0] lfsr_next(logic [127:0] s);
    return {s[126:0], s[68] ^ s[67] ^ s[66] ^ s[63]};
  endfunction

  // command and data monitor sampled where the controller accepts
  always @(posedge clk) begin
    if (!rstn) begin
      wr_cmds     = 0;
      rd_cmds     = 0;
      wr_bursts   = 0;
      rd_bursts   = 0;
      wr_beats    = 0;
      open_beats  = 0;
      high_writes = 0;
      inv_reads   = 0;
      last_rd     = '0;
      saw_fail    = 1'b0;
    end else begin
      if (phase == memtest_pkg::fail) begin
        saw_fail = 1'b1;
      end
      if (req.wdata_en && rsp.wdata_rdy) begin
        wr_beats++;
        if (!req.wdata_end) begin
          open_beats++;
        end
      end
      if (req.cmd_en && rsp.cmd_rdy) begin
        acc_lin = linear_of(req.addr);
        if (req.cmd == mig_app_pkg::APP_CMD_WRITE) begin
          wr_cmds++;
          if (req.burst_number == 6'd7) begin
            wr_bursts++;
            if (acc_lin >= HALF) begin
              high_writes++;
            end
          end
        end else begin
          rd_cmds++;
          if (req.burst_number == 6'd7) begin
            rd_bursts++;
          end
          if (phase == memtest_pkg::inv_check) begin
            inv_reads++;
            last_rd = acc_lin;
          end
        end
      end
    end
  end

  task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic start_run(logic alias_en, int stall, logic corrupt);
    @(negedge clk);
    rstn          = 1'b0;
    calib         = 1'b0;
    alias_on      = alias_en;
    stall_pct     = stall;
    corrupt_first = corrupt;
    fault_arm     = 1'b0;
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    repeat (5) @(negedge clk);
  endtask

  task automatic wait_done(string name);
    int n;
    n = 0;
    while (!status.done && n < RUN_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!status.done) begin
      errors++;
      $display("%s: the run never reached done", name);
    end
  endtask

  // every word holds the inverted pattern of its own index
  task automatic check_memory(string name, int words);
    logic [127:0] l;
    l = memtest_pkg::PATTERN_SEED;
    for (int w = 0; w < words; w++) begin
      check_value($sformatf("%s.mem[%0d]", name, w), ~l, u_dram.mem[w]);
      l = lfsr_next(l);
    end
  endtask

  task automatic test_calib_wait();
    int n;
    int early;
    start_run(1'b0, 0, 1'b0);
    calib = 1'b1;
    repeat (100) @(negedge clk);
    // short drop restarts the count
    calib = 1'b0;
    repeat (3) @(negedge clk);
    calib = 1'b1;
    n     = 0;
    early = 0;
    while (phase == memtest_pkg::wait_init && n < 1000) begin
      if (req.cmd_en || req.wdata_en) begin
        early++;
      end
      @(negedge clk);
      n++;
    end
    check_value("calib_wait.cycles", memtest_pkg::CALIB_WAIT, n);
    check_value("calib_wait.early_strobes", 0, early);
    check_value("calib_wait.phase", memtest_pkg::probe, phase);
  endtask

  task automatic test_clean_run(string name, int stall);
    start_run(1'b0, stall, 1'b0);
    calib = 1'b1;
    wait_done(name);
    check_value({name, ".done"}, 1, status.done);
    check_value({name, ".pass"}, 1, status.pass);
    check_value({name, ".half_size"}, 0, status.half_size);
    check_value({name, ".write_bursts"}, 2 * BURSTS, wr_bursts);
    check_value({name, ".read_bursts"}, 2 * BURSTS, rd_bursts);
    // two marker beats plus eight beats per burst of both fills
    check_value({name, ".data_beats"}, 2 + 2 * BURSTS * 8, wr_beats);
    // a 128-bit beat fills one whole DRAM burst
    check_value({name, ".beats_without_end"}, 0, open_beats);
    check_memory(name, WORDS);
  endtask

  task automatic test_half_size();
    start_run(1'b1, 20, 1'b0);
    calib = 1'b1;
    wait_done("half_size");
    check_value("half_size.done", 1, status.done);
    check_value("half_size.pass", 1, status.pass);
    check_value("half_size.half_size", 1, status.half_size);
    check_value("half_size.high_writes", 0, high_writes);
    check_value("half_size.write_bursts", BURSTS, wr_bursts);
    check_memory("half_size", WORDS / 2);
  endtask

  task automatic test_probe_error();
    start_run(1'b0, 0, 1'b1);
    calib = 1'b1;
    wait_done("probe_error");
    check_value("probe_error.done", 1, status.done);
    check_value("probe_error.pass", 0, status.pass);
    check_value("probe_error.probe_error", 1, status.probe_error);
    check_value("probe_error.write_cmds", 2, wr_cmds);
    check_value("probe_error.read_cmds", 1, rd_cmds);
    check_value("probe_error.bursts", 0, wr_bursts + rd_bursts);
  endtask

  task automatic test_inverse_fault();
    int n;
    start_run(1'b0, 0, 1'b0);
    calib = 1'b1;
    n     = 0;
    while (phase != memtest_pkg::inv_check && !status.done && n < RUN_CYCLES) begin
      @(negedge clk);
      n++;
    end
    fault_word = FAULT_WORD;
    fault_arm  = 1'b1;
    wait_done("inverse_fault");
    check_value("inverse_fault.done", 1, status.done);
    check_value("inverse_fault.pass", 0, status.pass);
    check_value("inverse_fault.saw_fail", 1, saw_fail);
    check_value("inverse_fault.inv_reads", FAULT_WORD / 8 + 1, inv_reads);
    check_value("inverse_fault.last_read", (FAULT_WORD / 8) * 64, last_rd);
  endtask

  // watchdog sized from six runs of four sweeps
  initial begin
    #(NUM_RUNS * RUN_CYCLES * 20);
    $display("watchdog expired before the tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    errors        = 0;
    rstn          = 1'b0;
    calib         = 1'b0;
    alias_on      = 1'b0;
    stall_pct     = 0;
    corrupt_first = 1'b0;
    fault_arm     = 1'b0;
    fault_word    = 0;
    test_calib_wait();
    test_clean_run("full_size", 0);
    test_half_size();
    test_probe_error();
    test_inverse_fault();
    test_clean_run("back_pressure", 60);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sim/memtest_properties.sv
`timescale 1ns/100ps

module memtest_properties (
  input logic                  clk,
  input logic                  rstn,
  input mig_app_pkg::app_req_t app_req_i,
  input mig_app_pkg::app_rsp_t app_rsp_i,
  input memtest_pkg::phase_e   phase_i
);

  logic idle_phase;

  assign idle_phase = (phase_i == memtest_pkg::wait_init) || (phase_i == memtest_pkg::done);

  // command strobe only after ready was seen high
  cmd_after_ready: assert property (
    @(posedge clk) disable iff (!rstn)
    !app_rsp_i.cmd_rdy |=> !app_req_i.cmd_en
  ) else $error("cmd_en high after a cycle with cmd_rdy low");

  wdata_after_ready: assert property (
    @(posedge clk) disable iff (!rstn)
    !app_rsp_i.wdata_rdy |=> !app_req_i.wdata_en
  ) else $error("wdata_en high after a cycle with wdata_rdy low");

  // port stays quiet before calibration and after the end
  quiet_when_idle: assert property (
    @(posedge clk) disable iff (!rstn)
    idle_phase |-> !app_req_i.cmd_en && !app_req_i.wdata_en
  ) else $error("request strobe while phase is wait_init or done");

endmodule

bind memtest_top memtest_properties u_properties (
  .clk       (clk),
  .rstn      (rstn),
  .app_req_i (app_req_o),
  .app_rsp_i (app_rsp_i),
  .phase_i   (phase_o)
);

//--- sim/dram_model.sv
`timescale 1ns/100ps

module dram_model #(
  parameter int ADDR_W = 12
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  alias_i,
  input  int                    stall_pct_i,
  input  logic                  corrupt_first_i,
  input  logic                  fault_arm_i,
  input  int                    fault_word_i,
  input  mig_app_pkg::app_req_t req_i,
  output mig_app_pkg::app_rsp_t rsp_o
);

  // one 128-bit word covers 8 address units
  localparam int WORDS = 2 ** (ADDR_W - 3);

  logic [127:0] mem [WORDS];
  logic [127:0] wdata_q [$];
  logic [127:0] rdata_q [$];
  logic [127:0] word;
  int           seed = 95015;
  int           lat;
  int           base;
  bit           first_read;
  bit           fault_used;

  // port word is bank, row, col; back to the flat count here
  function automatic int word_index(logic [26:0] port, logic alias_en);
    logic [26:0] flat;
    flat = {port[23:10], port[26:24], port[9:0]};
    if (alias_en) begin
      flat[ADDR_W-1] = 1'b0;
    end
    return int'(flat[ADDR_W-1:3]);
  endfunction

  // accept strobes at the rising edge
  always @(posedge clk) begin
    if (!rstn) begin
      wdata_q.delete();
      rdata_q.delete();
      first_read = 1'b1;
      fault_used = 1'b0;
      lat        = 0;
    end else begin
      if (req_i.wdata_en && rsp_o.wdata_rdy) begin
        wdata_q.push_back(req_i.wdata);
      end
      if (req_i.cmd_en && rsp_o.cmd_rdy) begin
        base = word_index(req_i.addr, alias_i);
        if (req_i.cmd == mig_app_pkg::APP_CMD_WRITE) begin
          for (int i = 0; i <= int'(req_i.burst_number); i++) begin
            if (wdata_q.size() > 0) begin
              mem[base+i] = wdata_q.pop_front();
            end
          end
        end else begin
          // injected fault lands just before the read
          if (fault_arm_i && !fault_used) begin
            mem[fault_word_i][0] = ~mem[fault_word_i][0];
            fault_used = 1'b1;
          end
          for (int i = 0; i <= int'(req_i.burst_number); i++) begin
            word = mem[base+i];
            if (corrupt_first_i && first_read && i == 0) begin
              word = ~word;
            end
            rdata_q.push_back(word);
          end
          first_read = 1'b0;
          lat = 1 + int'($unsigned($random(seed)) % 5);
        end
      end
    end
  end

  // ready levels and read beats change on the falling edge
  always @(negedge clk) begin
    if (!rstn) begin
      rsp_o = '0;
    end else begin
      rsp_o.cmd_rdy     = ($unsigned($random(seed)) % 100) >= stall_pct_i;
      rsp_o.wdata_rdy   = ($unsigned($random(seed)) % 100) >= stall_pct_i;
      rsp_o.rdata_valid = 1'b0;
      rsp_o.rdata_end   = 1'b0;
      if (rdata_q.size() > 0) begin
        if (lat > 0) begin
          lat = lat - 1;
        end else begin
          rsp_o.rdata_valid = 1'b1;
          rsp_o.rdata       = rdata_q.pop_front();
          rsp_o.rdata_end   = rdata_q.size() == 0;
        end
      end
    end
  end

endmodule

//--- logic/memtest_top.sv
`timescale 1ns/100ps

module memtest_top #(
  parameter int ADDR_W = 27
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  init_calib_complete_i,
  input  mig_app_pkg::app_rsp_t app_rsp_i,
  output mig_app_pkg::app_req_t app_req_o,
  output memtest_pkg::phase_e   phase_o,
  output memtest_pkg::status_t  status_o
);

  localparam int CNT_W = $clog2(memtest_pkg::CALIB_WAIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(memtest_pkg::CALIB_WAIT - 1);

  memtest_pkg::phase_e   phase;
  logic [CNT_W-1:0]      calib_cnt;
  logic                  start_q;
  logic                  fail_seen;
  logic                  probe_err;
  logic                  invert;
  mig_app_pkg::app_req_t probe_req;
  mig_app_pkg::app_req_t sweep_req;
  logic                  probe_done;
  logic                  probe_ok;
  logic                  half_size;
  logic                  sweep_done;
  logic                  sweep_mismatch;

  assign invert = (phase == memtest_pkg::inv_fill) || (phase == memtest_pkg::inv_check);

  size_probe #(
    .ADDR_W (ADDR_W)
  ) u_probe (
    .clk                   (clk),
    .rstn                  (rstn),
    .init_calib_complete_i (init_calib_complete_i),
    .app_rsp_i             (app_rsp_i),
    .probe_req_o           (probe_req),
    .probe_done_o          (probe_done),
    .probe_ok_o            (probe_ok),
    .half_size_o           (half_size)
  );

  burst_sweeper #(
    .ADDR_W (ADDR_W)
  ) u_sweeper (
    .clk              (clk),
    .rstn             (rstn),
    .start_i          (start_q),
    .invert_i         (invert),
    .half_size_i      (half_size),
    .app_rsp_i        (app_rsp_i),
    .sweep_req_o      (sweep_req),
    .sweep_done_o     (sweep_done),
    .sweep_mismatch_o (sweep_mismatch)
  );

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      phase     <= memtest_pkg::wait_init;
      calib_cnt <= '0;
      start_q   <= 1'b0;
      fail_seen <= 1'b0;
      probe_err <= 1'b0;
    end else begin
      start_q <= 1'b0;
      case (phase)
        memtest_pkg::wait_init: begin
          // tracks the probe's own settle count edge for edge
          if (!init_calib_complete_i) begin
            calib_cnt <= '0;
          end else if (calib_cnt == CNT_LAST) begin
            phase <= memtest_pkg::probe;
          end else begin
            calib_cnt <= calib_cnt + 1'b1;
          end
        end
        memtest_pkg::probe: begin
          if (probe_done) begin
            if (probe_ok) begin
              phase   <= memtest_pkg::fill;
              start_q <= 1'b1;
            end else begin
              phase     <= memtest_pkg::done;
              probe_err <= 1'b1;
            end
          end
        end
        memtest_pkg::fill: begin
          if (sweep_done) begin
            phase   <= memtest_pkg::check;
            start_q <= 1'b1;
          end
        end
        memtest_pkg::check: begin
          if (sweep_mismatch) begin
            phase     <= memtest_pkg::fail;
            fail_seen <= 1'b1;
          end else if (sweep_done) begin
            phase   <= memtest_pkg::inv_fill;
            start_q <= 1'b1;
          end
        end
        memtest_pkg::inv_fill: begin
          if (sweep_done) begin
            phase   <= memtest_pkg::inv_check;
            start_q <= 1'b1;
          end
        end
        memtest_pkg::inv_check: begin
          if (sweep_mismatch) begin
            phase     <= memtest_pkg::fail;
            fail_seen <= 1'b1;
          end else if (sweep_done) begin
            phase <= memtest_pkg::done;
          end
        end
        memtest_pkg::fail: begin
          phase <= memtest_pkg::done;
        end
        default: begin
        end
      endcase
    end
  end

  // probe owns the port only while probing
  assign app_req_o = (phase == memtest_pkg::probe) ? probe_req : sweep_req;
  assign phase_o   = phase;

  always_comb begin
    status_o.done        = phase == memtest_pkg::done;
    status_o.pass        = (phase == memtest_pkg::done) && !fail_seen && !probe_err;
    status_o.half_size   = half_size;
    status_o.probe_error = probe_err;
  end

endmodule

//--- logic/burst_sweeper.sv
`timescale 1ns/100ps

module burst_sweeper #(
  parameter int ADDR_W = 27
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  start_i,
  input  logic                  invert_i,
  input  logic                  half_size_i,
  input  mig_app_pkg::app_rsp_t app_rsp_i,
  output mig_app_pkg::app_req_t sweep_req_o,
  output logic                  sweep_done_o,
  output logic                  sweep_mismatch_o
);

  localparam int BEAT_W = $clog2(mig_app_pkg::BURST_BEATS);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(mig_app_pkg::BURST_BEATS - 1);
  localparam logic [ADDR_W:0] STRIDE = (ADDR_W + 1)'(mig_app_pkg::BURST_STRIDE);

  typedef enum logic [2:0] {
    st_idle,
    st_wdata,
    st_wcmd,
    st_rcmd,
    st_rdata
  } sweep_state_e;

  sweep_state_e                       state;
  logic                               check_mode;
  logic [ADDR_W-1:0]                  addr_cnt;
  logic [ADDR_W:0]                    next_addr;
  logic                               last_burst;
  logic [BEAT_W-1:0]                  beat_cnt;
  logic                               cmd_en_q;
  logic                               wdata_en_q;
  logic                               cmd_acc;
  logic                               wdata_acc;
  logic                               beat_bad;
  logic                               lfsr_step;
  logic [127:0]                       lfsr_word;
  logic [mig_app_pkg::APP_DATA_W-1:0] expect_word;
  mig_app_pkg::app_addr_u             burst_addr;

  pattern_lfsr u_pattern (
    .clk    (clk),
    .rstn   (rstn),
    .load_i (start_i),
    .step_i (lfsr_step),
    .word_o (lfsr_word)
  );

  // same word is written in a fill and expected in the check
  assign expect_word = lfsr_word ^ {mig_app_pkg::APP_DATA_W{invert_i}};

  assign cmd_acc   = cmd_en_q && app_rsp_i.cmd_rdy;
  assign wdata_acc = wdata_en_q && app_rsp_i.wdata_rdy;
  assign beat_bad  = app_rsp_i.rdata != expect_word;
  assign lfsr_step = wdata_acc || (state == st_rdata && app_rsp_i.rdata_valid && !beat_bad);

  // sweep end is the first carry into the size limit bit
  assign next_addr  = {1'b0, addr_cnt} + STRIDE;
  assign last_burst = half_size_i ? next_addr[ADDR_W-1] : next_addr[ADDR_W];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state            <= st_idle;
      check_mode       <= 1'b0;
      addr_cnt         <= '0;
      beat_cnt         <= '0;
      cmd_en_q         <= 1'b0;
      wdata_en_q       <= 1'b0;
      sweep_done_o     <= 1'b0;
      sweep_mismatch_o <= 1'b0;
    end else begin
      sweep_done_o     <= 1'b0;
      sweep_mismatch_o <= 1'b0;
      if (start_i) begin
        addr_cnt <= '0;
        beat_cnt <= '0;
        state    <= check_mode ? st_rcmd : st_wdata;
      end else begin
        case (state)
          st_wdata: begin
            wdata_en_q <= !wdata_en_q && app_rsp_i.wdata_rdy;
            if (wdata_acc) begin
              beat_cnt <= beat_cnt + 1'b1;
              if (beat_cnt == LAST_BEAT) begin
                state <= st_wcmd;
              end
            end
          end
          st_wcmd: begin
            cmd_en_q <= !cmd_en_q && app_rsp_i.cmd_rdy;
            if (cmd_acc) begin
              if (last_burst) begin
                sweep_done_o <= 1'b1;
                check_mode   <= 1'b1;
                state        <= st_idle;
              end else begin
                addr_cnt <= next_addr[ADDR_W-1:0];
                state    <= st_wdata;
              end
            end
          end
          st_rcmd: begin
            cmd_en_q <= !cmd_en_q && app_rsp_i.cmd_rdy;
            if (cmd_acc) begin
              state <= st_rdata;
            end
          end
          st_rdata: begin
            if (app_rsp_i.rdata_valid) begin
              if (beat_bad) begin
                // stop on the first bad beat, rest of the burst is dropped
                sweep_mismatch_o <= 1'b1;
                state            <= st_idle;
              end else begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == LAST_BEAT) begin
                  if (last_burst) begin
                    sweep_done_o <= 1'b1;
                    check_mode   <= 1'b0;
                    state        <= st_idle;
                  end else begin
                    addr_cnt <= next_addr[ADDR_W-1:0];
                    state    <= st_rcmd;
                  end
                end
              end
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_comb begin
    burst_addr                     = '0;
    burst_addr.linear[ADDR_W-1:0]  = addr_cnt;
    sweep_req_o.cmd_en             = cmd_en_q;
    sweep_req_o.cmd                = check_mode ? mig_app_pkg::APP_CMD_READ
                                                : mig_app_pkg::APP_CMD_WRITE;
    sweep_req_o.addr               = mig_app_pkg::port_addr(burst_addr);
    sweep_req_o.burst_number       = 6'(mig_app_pkg::BURST_BEATS - 1);
    sweep_req_o.wdata_en           = wdata_en_q;
    // each beat is a full burst on the port
    sweep_req_o.wdata_end          = wdata_en_q;
    sweep_req_o.wdata              = expect_word;
  end

endmodule

//--- logic/size_probe.sv
`timescale 1ns/100ps

module size_probe #(
  parameter int ADDR_W = 27
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  init_calib_complete_i,
  input  mig_app_pkg::app_rsp_t app_rsp_i,
  output mig_app_pkg::app_req_t probe_req_o,
  output logic                  probe_done_o,
  output logic                  probe_ok_o,
  output logic                  half_size_o
);

  localparam int CNT_W = $clog2(memtest_pkg::CALIB_WAIT);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(memtest_pkg::CALIB_WAIT - 1);

  typedef enum logic [2:0] {
    p_calib,
    p_wdata,
    p_wcmd,
    p_rcmd,
    p_rwait,
    p_idle
  } probe_state_e;

  probe_state_e           state;
  logic [CNT_W-1:0]       calib_cnt;
  logic                   hi_sel;
  logic                   cmd_en_q;
  logic                   wdata_en_q;
  logic                   cmd_acc;
  logic                   wdata_acc;
  logic                   is_low;
  logic                   is_high;
  mig_app_pkg::app_addr_u probe_addr;

  assign cmd_acc   = cmd_en_q && app_rsp_i.cmd_rdy;
  assign wdata_acc = wdata_en_q && app_rsp_i.wdata_rdy;
  assign is_low    = app_rsp_i.rdata == memtest_pkg::MARKER_LOW;
  assign is_high   = app_rsp_i.rdata == memtest_pkg::MARKER_HIGH;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state        <= p_calib;
      calib_cnt    <= '0;
      hi_sel       <= 1'b0;
      cmd_en_q     <= 1'b0;
      wdata_en_q   <= 1'b0;
      probe_done_o <= 1'b0;
      probe_ok_o   <= 1'b0;
      half_size_o  <= 1'b0;
    end else begin
      probe_done_o <= 1'b0;
      probe_ok_o   <= 1'b0;
      case (state)
        p_calib: begin
          // any drop in calibration restarts the wait
          if (!init_calib_complete_i) begin
            calib_cnt <= '0;
          end else if (calib_cnt == CNT_LAST) begin
            state <= p_wdata;
          end else begin
            calib_cnt <= calib_cnt + 1'b1;
          end
        end
        p_wdata: begin
          wdata_en_q <= !wdata_en_q && app_rsp_i.wdata_rdy;
          if (wdata_acc) begin
            state <= p_wcmd;
          end
        end
        p_wcmd: begin
          cmd_en_q <= !cmd_en_q && app_rsp_i.cmd_rdy;
          if (cmd_acc) begin
            // low marker first, then the high one, then read back
            hi_sel <= !hi_sel;
            state  <= hi_sel ? p_rcmd : p_wdata;
          end
        end
        p_rcmd: begin
          cmd_en_q <= !cmd_en_q && app_rsp_i.cmd_rdy;
          if (cmd_acc) begin
            state <= p_rwait;
          end
        end
        p_rwait: begin
          if (app_rsp_i.rdata_valid) begin
            probe_done_o <= 1'b1;
            probe_ok_o   <= is_low || is_high;
            // high marker at address 0 means the top bit is ignored
            half_size_o  <= is_high;
            state        <= p_idle;
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    probe_addr                    = '0;
    probe_addr.linear[ADDR_W-1]   = hi_sel;
    probe_req_o.cmd_en            = cmd_en_q;
    probe_req_o.cmd               = (state == p_rcmd) ? mig_app_pkg::APP_CMD_READ
                                                      : mig_app_pkg::APP_CMD_WRITE;
    probe_req_o.addr              = mig_app_pkg::port_addr(probe_addr);
    // single beat per marker
    probe_req_o.burst_number      = 6'd0;
    probe_req_o.wdata_en          = wdata_en_q;
    probe_req_o.wdata_end         = wdata_en_q;
    probe_req_o.wdata             = hi_sel ? memtest_pkg::MARKER_HIGH
                                           : memtest_pkg::MARKER_LOW;
  end

endmodule

//--- logic/pattern_lfsr.sv
`timescale 1ns/100ps

module pattern_lfsr (
  input  logic         clk,
  input  logic         rstn,
  input  logic         load_i,
  input  logic         step_i,
  output logic [127:0] word_o
);

  logic [127:0] lfsr;
  logic         feedback;

  // taps 68, 67, 66, 63 into bit 0
  assign feedback = lfsr[68] ^ lfsr[67] ^ lfsr[66] ^ lfsr[63];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      lfsr <= memtest_pkg::PATTERN_SEED;
    end else if (load_i) begin
      // restart the sequence for a new sweep
      lfsr <= memtest_pkg::PATTERN_SEED;
    end else if (step_i) begin
      lfsr <= {lfsr[126:0], feedback};
    end
  end

  assign word_o = lfsr;

endmodule

//--- logic/memtest_pkg.sv
package memtest_pkg;

  // tester phases in run order
  typedef enum logic [2:0] {
    wait_init = 3'd0,
    probe     = 3'd1,
    fill      = 3'd2,
    check     = 3'd3,
    inv_fill  = 3'd4,
    inv_check = 3'd5,
    fail      = 3'd6,
    done      = 3'd7
  } phase_e;

  typedef struct packed {
    logic done;
    logic pass;
    logic half_size;
    logic probe_error;
  } status_t;

  // marker written at address 0
  localparam logic [127:0] MARKER_LOW = 128'h5A01_23FA_4567_89AB_CDEF_0123_4567_89AB;

  // marker written with the top address bit set
  localparam logic [127:0] MARKER_HIGH = 128'h5329_0AB2_FA05_00FF_89AB_CDEF_0123_4567;

  // start value of the sweep pattern
  localparam logic [127:0] PATTERN_SEED = 128'h0123_4567_890A_BCDE_FEDC_BA98_7654_3210;

  // settle time after calibration, in cycles
  localparam int CALIB_WAIT = 256;

endpackage

//--- logic/mig_app_pkg.sv
package mig_app_pkg;

  // beat width of the native application port
  localparam int APP_DATA_W = 128;

  // widest address the port carries
  localparam int ADDR_MAX = 27;

  // one command moves 8 beats, 64 address units
  localparam int BURST_BEATS = 8;
  localparam int BURST_STRIDE = 64;

  typedef enum logic [2:0] {
    APP_CMD_WRITE = 3'd0,
    APP_CMD_READ  = 3'd1
  } app_cmd_e;

  // flat count seen by the tester, split into bank/row/col for the port.
  // col comes from the low bits and bank sits just above it, so the top
  // count bit lands in the row field
  typedef union packed {
    logic [ADDR_MAX-1:0] linear;
    struct packed {
      logic [13:0] row;
      logic [2:0]  bank;
      logic [9:0]  col;
    } fields;
  } app_addr_u;

  typedef struct packed {
    logic                  cmd_en;
    app_cmd_e              cmd;
    logic [ADDR_MAX-1:0]   addr;
    logic [5:0]            burst_number;
    logic                  wdata_en;
    logic                  wdata_end;
    logic [APP_DATA_W-1:0] wdata;
  } app_req_t;

  typedef struct packed {
    logic                  cmd_rdy;
    logic                  wdata_rdy;
    logic                  rdata_valid;
    logic                  rdata_end;
    logic [APP_DATA_W-1:0] rdata;
  } app_rsp_t;

  // port word is bank, row, col from the top down
  function automatic logic [ADDR_MAX-1:0] port_addr(app_addr_u a);
    return {a.fields.bank, a.fields.row, a.fields.col};
  endfunction

endpackage
